//--- logic/tiling_pkg.sv
package tiling_pkg;

	// largest tile edge in pixels
	localparam int TILE_EDGE = 52;

	// origin step between neighboring tiles
	// tile edge minus the two pixel overlap of a 3x3 kernel
	localparam int TILE_STEP = 50;

	// map coordinate or map size
	typedef logic [9:0] coord_t;

	// one run, held stable while the walk is active
	typedef struct packed {
		coord_t map_size;
		coord_t channels;
	} fetch_cfg_t;

endpackage

//--- logic/dma_pkg.sv
package dma_pkg;

	// DRAM byte address
	typedef logic [31:0] dram_addr_t;

	// one row request as it leaves the walker
	typedef struct packed {
		dram_addr_t dram_start;
		dram_addr_t dram_end;
		logic [6:0] buf_words;
		// final row of the run
		logic       last;
	} row_desc_t;

	// request as seen by the DMA engine
	typedef struct packed {
		dram_addr_t dram_start;
		dram_addr_t dram_end;
		logic [6:0] buf_words;
		// ping-pong line buffer
		logic       buf_slot;
	} dma_req_t;

endpackage

//--- logic/tile_walker.sv
`timescale 1ns/1ps

module tile_walker (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   run,
	input  tiling_pkg::fetch_cfg_t cfg,
	output logic                   push_valid,
	output dma_pkg::row_desc_t     push_desc,
	input  logic                   push_ready
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_SETUP,
		ST_WALK
	} state_t;

	state_t state;

	tiling_pkg::coord_t col_org;
	tiling_pkg::coord_t row_org;
	tiling_pkg::coord_t chan;
	tiling_pkg::coord_t row;
	tiling_pkg::coord_t col_len;
	tiling_pkg::coord_t row_len;
	logic col_last;
	logic row_last;
	logic row_end;
	logic chan_end;
	logic step;

	// all in words, byte address is formed on output
	dma_pkg::dram_addr_t plane;
	dma_pkg::dram_addr_t row_base;
	dma_pkg::dram_addr_t chan_base;
	dma_pkg::dram_addr_t row_addr;
	dma_pkg::dram_addr_t map_size_w;
	dma_pkg::dram_addr_t next_tile;

	assign map_size_w = dma_pkg::dram_addr_t'(cfg.map_size);

	// edge tiles get clipped to what is left of the map
	assign col_last = {1'b0, col_org} + 11'(tiling_pkg::TILE_EDGE) >= {1'b0, cfg.map_size};
	assign row_last = {1'b0, row_org} + 11'(tiling_pkg::TILE_EDGE) >= {1'b0, cfg.map_size};
	assign col_len = col_last ? cfg.map_size - col_org
		: tiling_pkg::coord_t'(tiling_pkg::TILE_EDGE);
	assign row_len = row_last ? cfg.map_size - row_org
		: tiling_pkg::coord_t'(tiling_pkg::TILE_EDGE);

	assign row_end = (row == row_len - 1'b1);
	assign chan_end = (chan == cfg.channels - 1'b1);
	assign step = push_valid && push_ready;

	// channel 0 base of the following tile, across first then down
	always_comb
	begin
		if (!col_last)
			next_tile = row_base + dma_pkg::dram_addr_t'(col_org)
				+ dma_pkg::dram_addr_t'(tiling_pkg::TILE_STEP);
		else
			next_tile = row_base + dma_pkg::dram_addr_t'(tiling_pkg::TILE_STEP) * map_size_w;
	end

	always_ff @(posedge clk, posedge rst)
	begin
		if (rst)
		begin
			state <= ST_IDLE;
			col_org <= '0;
			row_org <= '0;
			chan <= '0;
			row <= '0;
			plane <= '0;
			row_base <= '0;
			chan_base <= '0;
			row_addr <= '0;
		end
		else
		begin
			case (state)
				ST_IDLE:
					if (run)
						state <= ST_SETUP;
				ST_SETUP:
				begin
					// the only multiply, once per run
					plane <= map_size_w * map_size_w;
					col_org <= '0;
					row_org <= '0;
					chan <= '0;
					row <= '0;
					row_base <= '0;
					chan_base <= '0;
					row_addr <= '0;
					state <= ST_WALK;
				end
				ST_WALK:
					if (step)
					begin
						if (!row_end)
						begin
							row <= row + 1'b1;
							row_addr <= row_addr + map_size_w;
						end
						else if (!chan_end)
						begin
							row <= '0;
							chan <= chan + 1'b1;
							chan_base <= chan_base + plane;
							row_addr <= chan_base + plane;
						end
						else if (!(col_last && row_last))
						begin
							row <= '0;
							chan <= '0;
							chan_base <= next_tile;
							row_addr <= next_tile;
							if (!col_last)
								col_org <= col_org + tiling_pkg::coord_t'(tiling_pkg::TILE_STEP);
							else
							begin
								col_org <= '0;
								row_org <= row_org + tiling_pkg::coord_t'(tiling_pkg::TILE_STEP);
								row_base <= next_tile;
							end
						end
						else
							state <= ST_IDLE;
					end
				default:
					state <= ST_IDLE;
			endcase
		end
	end

	assign push_valid = (state == ST_WALK);
	assign push_desc.dram_start = row_addr << 2;
	assign push_desc.dram_end = (row_addr + dma_pkg::dram_addr_t'(col_len) - 1'b1) << 2;
	// 4 pixels per buffer word, rounded up
	assign push_desc.buf_words = 7'((col_len + 2'd3) >> 2);
	assign push_desc.last = row_end && chan_end && col_last && row_last;

endmodule

//--- logic/desc_fifo.sv
`timescale 1ns/1ps

module desc_fifo #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               push_valid,
	input  dma_pkg::row_desc_t push_desc,
	output logic               push_ready,
	output logic               pop_valid,
	output dma_pkg::row_desc_t pop_desc,
	input  logic               pop_ready
);

	localparam int AW = $clog2(FIFO_DEPTH);

	dma_pkg::row_desc_t mem [FIFO_DEPTH];

	// top bit is the wrap flag
	logic [AW:0] wr_ptr;
	logic [AW:0] rd_ptr;
	logic full;
	logic empty;

	assign empty = (wr_ptr == rd_ptr);
	assign full = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

	assign push_ready = !full;
	assign pop_valid = !empty;
	assign pop_desc = mem[rd_ptr[AW-1:0]];

	always_ff @(posedge clk)
	begin
		if (push_valid && push_ready)
			mem[wr_ptr[AW-1:0]] <= push_desc;
	end

	always_ff @(posedge clk, posedge rst)
	begin
		if (rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (push_valid && push_ready)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop_valid && pop_ready)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

endmodule

//--- logic/dma_issuer.sv
`timescale 1ns/1ps

module dma_issuer (
	input  logic               clk,
	input  logic               rst,
	input  logic               pop_valid,
	input  dma_pkg::row_desc_t pop_desc,
	output logic               pop_ready,
	output logic               dma_start,
	output dma_pkg::dma_req_t  dma_req,
	input  logic               dma_done,
	output logic               done
);

	typedef enum logic {
		ST_IDLE,
		ST_WAIT
	} state_t;

	state_t state;

	// slot for the next request
	logic slot;
	// outstanding request closes the run
	logic last_req;

	assign pop_ready = (state == ST_IDLE) && pop_valid;

	always_ff @(posedge clk, posedge rst)
	begin
		if (rst)
		begin
			state <= ST_IDLE;
			slot <= 1'b0;
			last_req <= 1'b0;
			dma_start <= 1'b0;
			done <= 1'b0;
			dma_req <= '0;
		end
		else
		begin
			dma_start <= 1'b0;
			done <= 1'b0;
			case (state)
				ST_IDLE:
					if (pop_valid)
					begin
						// request held until the engine answers
						dma_req.dram_start <= pop_desc.dram_start;
						dma_req.dram_end <= pop_desc.dram_end;
						dma_req.buf_words <= pop_desc.buf_words;
						dma_req.buf_slot <= slot;
						slot <= !slot;
						last_req <= pop_desc.last;
						dma_start <= 1'b1;
						state <= ST_WAIT;
					end
				ST_WAIT:
					if (dma_done)
					begin
						done <= last_req;
						state <= ST_IDLE;
					end
				default:
					state <= ST_IDLE;
			endcase
		end
	end

endmodule

//--- logic/input_fetch_top.sv
`timescale 1ns/1ps

module input_fetch_top #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   run,
	input  tiling_pkg::fetch_cfg_t cfg,
	output logic                   dma_start,
	output dma_pkg::dma_req_t      dma_req,
	input  logic                   dma_done,
	output logic                   done
);

	// walker to FIFO
	logic               push_valid;
	logic               push_ready;
	dma_pkg::row_desc_t push_desc;

	// FIFO to issuer
	logic               pop_valid;
	logic               pop_ready;
	dma_pkg::row_desc_t pop_desc;

	tile_walker u_walker (
		.clk        (clk),
		.rst        (rst),
		.run        (run),
		.cfg        (cfg),
		.push_valid (push_valid),
		.push_desc  (push_desc),
		.push_ready (push_ready)
	);

	desc_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_fifo (
		.clk        (clk),
		.rst        (rst),
		.push_valid (push_valid),
		.push_desc  (push_desc),
		.push_ready (push_ready),
		.pop_valid  (pop_valid),
		.pop_desc   (pop_desc),
		.pop_ready  (pop_ready)
	);

	dma_issuer u_issuer (
		.clk       (clk),
		.rst       (rst),
		.pop_valid (pop_valid),
		.pop_desc  (pop_desc),
		.pop_ready (pop_ready),
		.dma_start (dma_start),
		.dma_req   (dma_req),
		.dma_done  (dma_done),
		.done      (done)
	);

endmodule

//--- tb/fetch_checker.sv
`timescale 1ns/1ps

module fetch_checker (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   run,
	input  tiling_pkg::fetch_cfg_t cfg,
	input  int                     exp_count,
	input  logic                   dma_start,
	input  dma_pkg::dma_req_t      dma_req,
	input  logic                   dma_done,
	input  logic                   done,
	output int                     errors,
	output int                     checked,
	output int                     runs_done
);

	// 3x3 kernel, stride 1
	localparam int EDGE = 52;
	localparam int STEP = 50;

	typedef struct packed {
		logic [31:0] dram_start;
		logic [31:0] dram_end;
		logic [6:0]  buf_words;
	} exp_row_t;

	exp_row_t          expected[$];
	dma_pkg::dma_req_t held;
	logic              outstanding;
	logic              done_due;
	logic              exp_slot;
	int                issued;
	int                run_exp;

	initial
	begin
		errors = 0;
		checked = 0;
		runs_done = 0;
	end

	task automatic flag(input string msg);
		$display("ERR %0t: %s", $time, msg);
		errors++;
	endtask

	// tiles across then down, channels, then rows of a tile
	task automatic build_expected(input int m, input int chans);
		int       row_org;
		int       col_org;
		int       len;
		int       rows;
		int       c;
		int       r;
		bit       rows_left;
		bit       cols_left;
		exp_row_t e;
		row_org = 0;
		rows_left = 1'b1;
		while (rows_left)
		begin
			col_org = 0;
			cols_left = 1'b1;
			while (cols_left)
			begin
				len = (m - col_org < EDGE) ? m - col_org : EDGE;
				rows = (m - row_org < EDGE) ? m - row_org : EDGE;
				for (c = 0; c < chans; c++)
				begin
					for (r = 0; r < rows; r++)
					begin
						e.dram_start = 32'(4 * (c * m * m + (row_org + r) * m + col_org));
						e.dram_end = e.dram_start + 32'(4 * (len - 1));
						e.buf_words = 7'((len + 3) / 4);
						expected.push_back(e);
					end
				end
				cols_left = (col_org + EDGE < m);
				col_org += STEP;
			end
			rows_left = (row_org + EDGE < m);
			row_org += STEP;
		end
	endtask

	always @(posedge clk)
	begin
		exp_row_t e;
		if (rst)
		begin
			if (dma_start || done)
				flag("dma_start or done active during reset");
			expected.delete();
			outstanding = 1'b0;
			done_due = 1'b0;
			exp_slot = 1'b0;
			issued = 0;
		end
		else
		begin
			if (run)
			begin
				build_expected(int'(cfg.map_size), int'(cfg.channels));
				if (expected.size() != exp_count)
					flag($sformatf("tiling gives %0d requests, data file %0d",
						expected.size(), exp_count));
				run_exp = exp_count;
				issued = 0;
			end
			if (done && !done_due)
				flag("done without a final dma_done one cycle before");
			if (!done && done_due)
				flag("done missing one cycle after the final dma_done");
			if (done)
			begin
				runs_done++;
				if (issued != run_exp)
					flag($sformatf("run issued %0d requests, expected %0d", issued, run_exp));
			end
			done_due = 1'b0;
			if (outstanding)
			begin
				if (dma_req !== held)
					flag("dma_req changed before dma_done");
				if (dma_start)
					flag("dma_start while a request is outstanding");
				if (dma_done)
				begin
					outstanding = 1'b0;
					done_due = (expected.size() == 0);
				end
			end
			else if (dma_start)
			begin
				if (expected.size() == 0)
					flag("dma_start with no request expected");
				else
				begin
					e = expected.pop_front();
					if (dma_req.dram_start !== e.dram_start)
						flag($sformatf("dram_start %h, expected %h", dma_req.dram_start,
							e.dram_start));
					if (dma_req.dram_end !== e.dram_end)
						flag($sformatf("dram_end %h, expected %h", dma_req.dram_end, e.dram_end));
					if (dma_req.buf_words !== e.buf_words)
						flag($sformatf("buf_words %0d, expected %0d", dma_req.buf_words,
							e.buf_words));
				end
				if (dma_req.buf_slot !== exp_slot)
					flag($sformatf("buf_slot %b, expected %b", dma_req.buf_slot, exp_slot));
				exp_slot = !exp_slot;
				held = dma_req;
				outstanding = 1'b1;
				issued++;
				checked++;
			end
		end
	end

endmodule

//--- tb/tb_input_fetch.sv
`timescale 1ns/1ps

module tb_input_fetch;

	localparam int HALF_PERIOD = 50;
	localparam int SEED = 68820;
	localparam int MAX_DELAY = 8;
	localparam int CYCLES_PER_REQ = 20;
	localparam int TIMEOUT_MARGIN = 200;

	logic                   clk;
	logic                   rst;
	logic                   run;
	tiling_pkg::fetch_cfg_t cfg;
	logic                   dma_start;
	dma_pkg::dma_req_t      dma_req;
	logic                   dma_done;
	logic                   done;

	int   exp_count;
	int   chk_errors;
	int   checked;
	int   runs_done;
	int   run_errors;
	int   total_reqs;
	int   timeout_limit;
	logic limit_ready;

	// one entry per line of the data file
	int run_maps[$];
	int run_chans[$];
	int run_counts[$];

	input_fetch_top #(
		.FIFO_DEPTH (4)
	) DUT (
		.clk       (clk),
		.rst       (rst),
		.run       (run),
		.cfg       (cfg),
		.dma_start (dma_start),
		.dma_req   (dma_req),
		.dma_done  (dma_done),
		.done      (done)
	);

	fetch_checker u_checker (
		.clk       (clk),
		.rst       (rst),
		.run       (run),
		.cfg       (cfg),
		.exp_count (exp_count),
		.dma_start (dma_start),
		.dma_req   (dma_req),
		.dma_done  (dma_done),
		.done      (done),
		.errors    (chk_errors),
		.checked   (checked),
		.runs_done (runs_done)
	);

	initial
	begin
		clk = 1'b0;
		forever #(HALF_PERIOD) clk = !clk;
	end

	task automatic report_and_finish(input bit failed);
		$display("errors: %0d checker, %0d bookkeeping; %0d requests checked over %0d runs",
			chk_errors, run_errors, checked, runs_done);
		if (!failed && chk_errors == 0 && run_errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	endtask

	// lines starting with # are comments
	task automatic read_runs(output bit ok);
		int    fd;
		int    m;
		int    c;
		int    n;
		string line;
		ok = 1'b0;
		total_reqs = 0;
		fd = $fopen("tb/fetch_testdata.txt", "r");
		if (fd != 0)
		begin
			while (!$feof(fd))
			begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() > 0 && line[0] != "#" && $sscanf(line, "%d %d %d", m, c, n) == 3)
				begin
					run_maps.push_back(m);
					run_chans.push_back(c);
					run_counts.push_back(n);
					total_reqs += n;
					ok = 1'b1;
				end
			end
			$fclose(fd);
		end
	endtask

	// DMA engine, answers each start after a random delay
	initial
	begin
		int delay;
		void'($urandom(SEED));
		dma_done = 1'b0;
		forever
		begin
			@(negedge clk);
			if (dma_start)
			begin
				delay = $urandom_range(MAX_DELAY, 1);
				repeat (delay) @(negedge clk);
				dma_done = 1'b1;
				@(negedge clk);
				dma_done = 1'b0;
			end
		end
	end

	initial
	begin
		int cycles;
		cycles = 0;
		wait (limit_ready);
		while (cycles < timeout_limit)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: the runs did not finish within %0d cycles", timeout_limit);
		report_and_finish(1'b1);
	end

	initial
	begin
		bit file_ok;
		rst = 1'b1;
		run = 1'b0;
		cfg = '0;
		exp_count = 0;
		run_errors = 0;
		limit_ready = 1'b0;
		read_runs(file_ok);
		if (!file_ok)
		begin
			$display("could not read any run from tb/fetch_testdata.txt");
			report_and_finish(1'b1);
		end
		else
		begin
			timeout_limit = total_reqs * CYCLES_PER_REQ + TIMEOUT_MARGIN;
			limit_ready = 1'b1;
			repeat (2) @(negedge clk);
			rst = 1'b0;
			foreach (run_maps[i])
			begin
				@(negedge clk);
				cfg.map_size = tiling_pkg::coord_t'(run_maps[i]);
				cfg.channels = tiling_pkg::coord_t'(run_chans[i]);
				exp_count = run_counts[i];
				run = 1'b1;
				@(negedge clk);
				run = 1'b0;
				do
					@(negedge clk);
				while (!done);
			end
			// let the checker see the final done
			repeat (2) @(negedge clk);
			if (runs_done != run_maps.size())
			begin
				$display("only %0d of %0d runs completed", runs_done, run_maps.size());
				run_errors++;
			end
			if (checked != total_reqs)
			begin
				$display("%0d requests seen, data file lists %0d", checked, total_reqs);
				run_errors++;
			end
			report_and_finish(1'b0);
		end
	end

endmodule

//--- tb/fetch_testdata.txt
# map_size channels expected_requests
# one run per line, decimal
8 2 16
52 1 52
53 2 220
102 1 208
120 2 744
5 3 15
1 1 1

//--- build.f
logic/tiling_pkg.sv
logic/dma_pkg.sv
logic/tile_walker.sv
logic/desc_fifo.sv
logic/dma_issuer.sv
logic/input_fetch_top.sv
tb/fetch_checker.sv
tb/tb_input_fetch.sv

//--- Makefile
# Verilator simulation of the input fetch testbench

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing -Wno-fatal -f build.f --top-module tb_input_fetch -Mdir obj_dir
	@out=$$(./obj_dir/Vtb_input_fetch); \
	echo "$$out"; \
	echo "$$out" | grep -qxF "Simulation finished: PASS"

clean:
	rm -rf obj_dir
